//--- src/axi_regmap_pkg.sv
package axi_regmap_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // bus widths
    ////////////////////////////////////////////////////////////////////////////

    // byte address, 8 word registers
    typedef logic [4:0]  axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_strb_t;
    typedef logic [1:0]  axi_resp_t;

    // word index inside the register window
    typedef logic [2:0]  reg_sel_t;

    // address bits that select the word
    localparam int sel_lo = 2;
    localparam int sel_hi = 4;

    localparam axi_resp_t resp_okay = 2'b00;

    ////////////////////////////////////////////////////////////////////////////
    // register map
    ////////////////////////////////////////////////////////////////////////////

    // index 1 and 5..7 read back as zero
    localparam reg_sel_t reg_address = 3'd0;
    localparam reg_sel_t reg_data    = 3'd2;
    localparam reg_sel_t reg_status  = 3'd3;
    localparam reg_sel_t reg_control = 3'd4;

    // status bits, overflow positions are write-one-to-clear
    localparam int stat_rx_overflow = 0;
    localparam int stat_rx_full     = 1;
    localparam int stat_rx_empty    = 2;
    localparam int stat_tx_overflow = 3;
    localparam int stat_tx_full     = 4;
    localparam int stat_tx_empty    = 5;

    // control bits
    localparam int ctrl_read     = 0;
    localparam int ctrl_count_lo = 1;
    localparam int ctrl_count_hi = 4;
    localparam int ctrl_start    = 7;

endpackage

//--- src/i2c_pkg.sv
package i2c_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [6:0] target_addr_t;
    typedef logic [3:0] byte_count_t;

    // fifo geometry
    localparam int fifo_depth = 16;
    typedef logic [3:0] fifo_ptr_t;
    // one extra bit so a full fifo is not read as empty
    typedef logic [$clog2(fifo_depth):0] fifo_count_t;

    // clocks per half scl period
    localparam int scl_half_cycles = 4;
    localparam int scl_timer_bits = $clog2(scl_half_cycles);
    typedef logic [scl_timer_bits-1:0] scl_timer_t;

    // bit position inside a byte, counts 7 down to 0
    typedef logic [2:0] bit_index_t;

    // byte engine states
    typedef enum logic [2:0] {
        idle,
        start,
        address,
        data,
        ack,
        stop
    } engine_state_t;

endpackage

//--- src/byte_fifo.sv
module byte_fifo import i2c_pkg::*;
(
    input  logic  axi_clk,
    input  logic  axi_resetn,
    input  logic  push,
    input  byte_t push_data,
    input  logic  pop,
    output byte_t pop_data,
    input  logic  clear_overflow,
    output logic  empty,
    output logic  full,
    output logic  overflow
);

    byte_t       mem [fifo_depth];
    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    fifo_count_t count;

    logic do_push;
    logic do_pop;

    assign empty = (count == '0);
    assign full  = (count == fifo_depth);

    // a push into a full fifo is dropped, a pop from an empty one ignored
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // head entry is always visible
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge axi_clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    // pointers wrap on their own at 16
    always_ff @(posedge axi_clk)
    begin
        if (!axi_resetn)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
            // sticky, a new overflow wins over a clear in the same cycle
            if (push && full)
                overflow <= 1'b1;
            else if (clear_overflow)
                overflow <= 1'b0;
        end
    end

endmodule

//--- src/axi_lite_port.sv
module axi_lite_port import axi_regmap_pkg::*;
(
    input  logic      axi_clk,
    input  logic      axi_resetn,

    // write address, data and response channels
    input  axi_addr_t awaddr,
    input  logic      awvalid,
    output logic      awready,
    input  axi_data_t wdata,
    input  axi_strb_t wstrb,
    input  logic      wvalid,
    output logic      wready,
    output axi_resp_t bresp,
    output logic      bvalid,
    input  logic      bready,

    // read address and data channels
    input  axi_addr_t araddr,
    input  logic      arvalid,
    output logic      arready,
    output axi_data_t rdata,
    output axi_resp_t rresp,
    output logic      rvalid,
    input  logic      rready,

    // register strobes toward the bank
    output logic      wr_strobe,
    output reg_sel_t  wr_sel,
    output axi_data_t wr_data,
    output axi_strb_t wr_strb,
    output logic      rd_strobe,
    output reg_sel_t  rd_sel,
    input  axi_data_t rd_value
);

    ////////////////////////////////////////////////////////////////////////////
    // write side
    ////////////////////////////////////////////////////////////////////////////

    // low from acceptance until the response is taken
    logic aw_en;
    logic wr_accept;

    // address and data must arrive together
    assign wr_accept = awvalid && wvalid && aw_en && !awready;

    always_ff @(posedge axi_clk)
    begin
        if (!axi_resetn)
        begin
            awready <= 1'b0;
            wready  <= 1'b0;
            aw_en   <= 1'b1;
            bvalid  <= 1'b0;
        end
        else
        begin
            // ready pulses for a single cycle
            awready <= wr_accept;
            wready  <= wr_accept;
            if (wr_accept)
                aw_en <= 1'b0;
            else if (bvalid && bready)
                aw_en <= 1'b1;
            // response follows the handshake cycle, holds until bready
            if (wr_strobe)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
        end
    end

    // master still holds address and data in the handshake cycle
    assign wr_strobe = awready && awvalid && wready && wvalid;
    assign wr_sel    = awaddr[sel_hi:sel_lo];
    assign wr_data   = wdata;
    assign wr_strb   = wstrb;
    assign bresp     = resp_okay;

    ////////////////////////////////////////////////////////////////////////////
    // read side
    ////////////////////////////////////////////////////////////////////////////

    reg_sel_t raddr_sel;

    always_ff @(posedge axi_clk)
    begin
        if (!axi_resetn)
        begin
            arready   <= 1'b0;
            rvalid    <= 1'b0;
            raddr_sel <= '0;
        end
        else
        begin
            // a pending rvalid holds off the next read
            arready <= arvalid && !arready && !rvalid;
            if (arvalid && !arready && !rvalid)
                raddr_sel <= araddr[sel_hi:sel_lo];
            if (rd_strobe)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    // read data is sampled once and held while rvalid waits
    always_ff @(posedge axi_clk)
    begin
        if (rd_strobe)
            rdata <= rd_value;
    end

    assign rd_strobe = arready && arvalid;
    assign rd_sel    = raddr_sel;
    assign rresp     = resp_okay;

endmodule

//--- src/i2c_reg_bank.sv
module i2c_reg_bank import axi_regmap_pkg::*, i2c_pkg::*;
(
    input  logic         axi_clk,
    input  logic         axi_resetn,
    input  logic         wr_strobe,
    input  reg_sel_t     wr_sel,
    input  axi_data_t    wr_data,
    input  axi_strb_t    wr_strb,
    input  logic         rd_strobe,
    input  reg_sel_t     rd_sel,
    output axi_data_t    rd_value,
    output logic         go,
    output logic         read_mode,
    output byte_count_t  byte_count,
    output target_addr_t target_addr,
    output byte_t        tx_byte,
    output logic         tx_empty,
    input  logic         tx_pop,
    input  byte_t        rx_byte,
    input  logic         rx_push,
    input  logic         done
);

    axi_data_t address_reg;
    axi_data_t control_reg;
    axi_data_t status_word;
    byte_t     rx_head;

    logic tx_push, tx_clear, tx_full, tx_overflow;
    logic rx_pop, rx_clear, rx_empty, rx_full, rx_overflow;

    // merge the strobed byte lanes into the old word
    function automatic axi_data_t merge_lanes(axi_data_t old_word, axi_data_t new_word,
                                             axi_strb_t strb);
        axi_data_t merged;
        merged = old_word;
        for (int lane = 0; lane < $bits(axi_strb_t); lane++)
        begin
            if (strb[lane])
                merged[lane*8 +: 8] = new_word[lane*8 +: 8];
        end
        return merged;
    endfunction

    always_ff @(posedge axi_clk)
    begin
        if (!axi_resetn)
        begin
            address_reg <= '0;
            control_reg <= '0;
        end
        else
        begin
            if (wr_strobe && wr_sel == reg_address)
                address_reg <= merge_lanes(address_reg, wr_data, wr_strb);
            // the engine drops the start bit when it finishes
            if (wr_strobe && wr_sel == reg_control)
                control_reg <= merge_lanes(control_reg, wr_data, wr_strb);
            else if (done)
                control_reg[ctrl_start] <= 1'b0;
        end
    end

    assign go          = control_reg[ctrl_start];
    assign read_mode   = control_reg[ctrl_read];
    assign byte_count  = control_reg[ctrl_count_hi:ctrl_count_lo];
    assign target_addr = address_reg[$bits(target_addr_t)-1:0];

    // only byte lane 0 of the data register reaches the tx fifo
    assign tx_push = wr_strobe && wr_sel == reg_data && wr_strb[0];
    assign rx_pop  = rd_strobe && rd_sel == reg_data;

    // one cycle overflow clears on status writes
    assign tx_clear = wr_strobe && wr_sel == reg_status && wr_strb[0] && wr_data[stat_tx_overflow];
    assign rx_clear = wr_strobe && wr_sel == reg_status && wr_strb[0] && wr_data[stat_rx_overflow];

    byte_fifo tx_fifo (
        .axi_clk        (axi_clk),
        .axi_resetn     (axi_resetn),
        .push           (tx_push),
        .push_data      (wr_data[7:0]),
        .pop            (tx_pop),
        .pop_data       (tx_byte),
        .clear_overflow (tx_clear),
        .empty          (tx_empty),
        .full           (tx_full),
        .overflow       (tx_overflow)
    );

    byte_fifo rx_fifo (
        .axi_clk        (axi_clk),
        .axi_resetn     (axi_resetn),
        .push           (rx_push),
        .push_data      (rx_byte),
        .pop            (rx_pop),
        .pop_data       (rx_head),
        .clear_overflow (rx_clear),
        .empty          (rx_empty),
        .full           (rx_full),
        .overflow       (rx_overflow)
    );

    // status word, unused bits read zero
    always_comb
    begin
        status_word = '0;
        status_word[stat_rx_overflow] = rx_overflow;
        status_word[stat_rx_full]     = rx_full;
        status_word[stat_rx_empty]    = rx_empty;
        status_word[stat_tx_overflow] = tx_overflow;
        status_word[stat_tx_full]     = tx_full;
        status_word[stat_tx_empty]    = tx_empty;
    end

    // read mux, the data register shows the rx head being popped
    always_comb
    begin
        case (rd_sel)
            reg_address: rd_value = address_reg;
            reg_data:    rd_value = axi_data_t'(rx_head);
            reg_status:  rd_value = status_word;
            reg_control: rd_value = control_reg;
            default:     rd_value = '0;
        endcase
    end

endmodule

//--- src/i2c_byte_engine.sv
module i2c_byte_engine import i2c_pkg::*;
(
    input  logic         axi_clk,
    input  logic         axi_resetn,
    input  logic         go,
    input  logic         read_mode,
    input  byte_count_t  byte_count,
    input  target_addr_t target_addr,
    input  byte_t        tx_byte,
    input  logic         tx_empty,
    output logic         tx_pop,
    output byte_t        rx_byte,
    output logic         rx_push,
    output logic         done,
    output logic         scl_line,
    output logic         sda_line_out,
    input  logic         sda_line_in
);

    engine_state_t state;
    scl_timer_t    half_timer;
    bit_index_t    bit_idx;
    byte_count_t   bytes_left;
    byte_count_t   bytes_next;
    byte_t         shift;

    // phase 0 is the scl low half, phase 1 the high half
    logic phase;
    logic tick;
    logic armed;
    logic reading;
    logic addr_ack;
    logic ack_end;
    logic more;
    logic sda_next;

    assign tick    = (half_timer == scl_timer_t'(scl_half_cycles - 1));
    assign ack_end = (state == ack) && tick && phase;

    // the address ack does not consume a byte
    assign bytes_next = addr_ack ? bytes_left : bytes_left - 1'b1;
    // a write with an empty tx fifo ends early
    assign more = (bytes_next != '0) && (reading || !tx_empty);

    assign tx_pop  = ack_end && more && !reading;
    assign rx_push = ack_end && !addr_ack && reading;
    assign rx_byte = shift;

    ////////////////////////////////////////////////////////////////////////////
    // line levels
    ////////////////////////////////////////////////////////////////////////////

    assign scl_line = (state == idle) || (state == start) || phase;

    always_comb
    begin
        case (state)
            start:   sda_next = !phase;
            address: sda_next = shift[7];
            data:    sda_next = reading ? 1'b1 : shift[7];
            // release for the target ack, else master ack or nack on the last byte
            ack:     sda_next = (addr_ack || !reading) ? 1'b1 : (bytes_left == 1);
            stop:    sda_next = 1'b0;
            default: sda_next = 1'b1;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge axi_clk)
    begin
        if (!axi_resetn)
        begin
            state        <= idle;
            phase        <= 1'b0;
            half_timer   <= '0;
            armed        <= 1'b0;
            reading      <= 1'b0;
            addr_ack     <= 1'b0;
            bit_idx      <= '0;
            bytes_left   <= '0;
            shift        <= '0;
            done         <= 1'b0;
            sda_line_out <= 1'b1;
        end
        else
        begin
            done <= 1'b0;
            // sda trails scl by a clock, so data moves only while scl is low
            sda_line_out <= sda_next;
            if (state == idle)
            begin
                phase      <= 1'b0;
                half_timer <= '0;
                // a new transfer needs go to drop first
                if (!go)
                    armed <= 1'b1;
                else if (armed)
                begin
                    armed      <= 1'b0;
                    state      <= start;
                    reading    <= read_mode;
                    bytes_left <= byte_count;
                end
            end
            else if (!tick)
                half_timer <= half_timer + 1'b1;
            else
            begin
                half_timer <= '0;
                phase      <= !phase;
                // state moves at the end of the scl high half
                if (phase)
                begin
                    case (state)
                        start:
                        begin
                            state   <= address;
                            shift   <= {target_addr, reading};
                            bit_idx <= 3'd7;
                        end
                        address, data:
                        begin
                            // read bits enter here, msb first
                            shift <= {shift[6:0], sda_line_in};
                            if (bit_idx == '0)
                            begin
                                state    <= ack;
                                addr_ack <= (state == address);
                            end
                            else
                                bit_idx <= bit_idx - 1'b1;
                        end
                        ack:
                        begin
                            bytes_left <= bytes_next;
                            if (more)
                            begin
                                state   <= data;
                                bit_idx <= 3'd7;
                                if (!reading)
                                    shift <= tx_byte;
                            end
                            else
                                state <= stop;
                        end
                        // sda rises in idle, done marks the stop condition
                        stop:
                        begin
                            state <= idle;
                            done  <= 1'b1;
                        end
                        default: state <= idle;
                    endcase
                end
            end
        end
    end

endmodule

//--- src/i2c_axi_top.sv
module i2c_axi_top import axi_regmap_pkg::*, i2c_pkg::*;
(
    input  logic      axi_clk,
    input  logic      axi_resetn,
    input  axi_addr_t awaddr,
    input  logic      awvalid,
    output logic      awready,
    input  axi_data_t wdata,
    input  axi_strb_t wstrb,
    input  logic      wvalid,
    output logic      wready,
    output axi_resp_t bresp,
    output logic      bvalid,
    input  logic      bready,
    input  axi_addr_t araddr,
    input  logic      arvalid,
    output logic      arready,
    output axi_data_t rdata,
    output axi_resp_t rresp,
    output logic      rvalid,
    input  logic      rready,
    output logic      scl_line,
    output logic      sda_line_out,
    input  logic      sda_line_in
);

    // port to bank
    logic         wr_strobe, rd_strobe;
    reg_sel_t     wr_sel, rd_sel;
    axi_data_t    wr_data, rd_value;
    axi_strb_t    wr_strb;

    // bank to engine and back
    logic         go, read_mode, tx_empty, tx_pop, rx_push, done;
    byte_count_t  byte_count;
    target_addr_t target_addr;
    byte_t        tx_byte, rx_byte;

    axi_lite_port port0 (
        .axi_clk (axi_clk), .axi_resetn (axi_resetn),
        .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
        .bresp (bresp), .bvalid (bvalid), .bready (bready),
        .araddr (araddr), .arvalid (arvalid), .arready (arready),
        .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
        .wr_strobe (wr_strobe), .wr_sel (wr_sel), .wr_data (wr_data), .wr_strb (wr_strb),
        .rd_strobe (rd_strobe), .rd_sel (rd_sel), .rd_value (rd_value)
    );

    i2c_reg_bank bank0 (
        .axi_clk (axi_clk), .axi_resetn (axi_resetn),
        .wr_strobe (wr_strobe), .wr_sel (wr_sel), .wr_data (wr_data), .wr_strb (wr_strb),
        .rd_strobe (rd_strobe), .rd_sel (rd_sel), .rd_value (rd_value),
        .go (go), .read_mode (read_mode), .byte_count (byte_count),
        .target_addr (target_addr), .tx_byte (tx_byte), .tx_empty (tx_empty),
        .tx_pop (tx_pop), .rx_byte (rx_byte), .rx_push (rx_push), .done (done)
    );

    i2c_byte_engine engine0 (
        .axi_clk (axi_clk), .axi_resetn (axi_resetn),
        .go (go), .read_mode (read_mode), .byte_count (byte_count),
        .target_addr (target_addr), .tx_byte (tx_byte), .tx_empty (tx_empty),
        .tx_pop (tx_pop), .rx_byte (rx_byte), .rx_push (rx_push), .done (done),
        .scl_line (scl_line), .sda_line_out (sda_line_out), .sda_line_in (sda_line_in)
    );

endmodule

//--- bench/i2c_target_model.sv
module i2c_target_model
(
    input  logic scl,
    input  logic sda,
    output logic sda_drive
);

    // bytes returned on reads, loaded by the testbench
    logic [7:0] read_bytes [16];

    // every byte seen on the bus, address bytes included
    logic [7:0] byte_log [$];

    int start_count = 0;
    int stop_count  = 0;

    int         bit_cnt   = 0;
    int         byte_cnt  = 0;
    logic       rw        = 1'b0;
    logic       read_over = 1'b0;
    logic [7:0] shift_in  = '0;

    // released until a transfer needs the line
    initial
    begin
        sda_drive = 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // start and stop conditions, sda moving while scl is high
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            start_count++;
            bit_cnt   = 0;
            byte_cnt  = 0;
            rw        = 1'b0;
            read_over = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
            stop_count++;
    end

    // bits 0..7 are data, slot 8 is the ack
    always @(posedge scl)
    begin
        if (bit_cnt < 8)
        begin
            shift_in = {shift_in[6:0], sda};
            bit_cnt++;
            if (bit_cnt == 8)
            begin
                byte_log.push_back(shift_in);
                if (byte_cnt == 0)
                    rw = shift_in[0];
            end
        end
        else
        begin
            // master nack ends the read
            if (rw && byte_cnt > 0 && sda)
                read_over = 1'b1;
            bit_cnt = 0;
            byte_cnt++;
        end
    end

    // the line only changes while scl is low
    always @(negedge scl)
    begin
        if (bit_cnt == 8)
            sda_drive = (byte_cnt == 0 || !rw) ? 1'b0 : 1'b1;
        else if (rw && byte_cnt > 0 && !read_over)
            sda_drive = read_bytes[byte_cnt-1][7-bit_cnt];
        else
            sda_drive = 1'b1;
    end

endmodule

//--- bench/i2c_axi_tb.sv
module i2c_axi_tb import axi_regmap_pkg::*, i2c_pkg::*;
();

    logic      axi_clk = 1'b0;
    logic      axi_resetn;
    axi_addr_t awaddr, araddr;
    logic      awvalid, awready, wvalid, wready, bvalid, bready;
    logic      arvalid, arready, rvalid, rready;
    axi_data_t wdata, rdata;
    axi_strb_t wstrb;
    axi_resp_t bresp, rresp;
    logic      scl_line, sda_line_out, sda_line_in;
    wire       sda_drive;

    int           errors = 0;
    int           checks = 0;
    int           test_errors;
    int           seed = 91897;
    int           base, starts, stops;
    axi_data_t    value, expected;
    axi_strb_t    strb;
    target_addr_t target;
    byte_t        sent [4];

    // open drain bus where either side can pull low
    assign sda_line_in = sda_line_out & sda_drive;

    always #2 axi_clk = ~axi_clk;

    i2c_axi_top dut0 (
        .axi_clk (axi_clk), .axi_resetn (axi_resetn),
        .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
        .bresp (bresp), .bvalid (bvalid), .bready (bready),
        .araddr (araddr), .arvalid (arvalid), .arready (arready),
        .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
        .scl_line (scl_line), .sda_line_out (sda_line_out), .sda_line_in (sda_line_in)
    );

    i2c_target_model model0 (.scl (scl_line), .sda (sda_line_in), .sda_drive (sda_drive));

    ////////////////////////////////////////////////////////////////////////////
    // checks and bus tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        assert (got === want)
        else
        begin
            errors++;
            $display("error at %0t: %s expected %h got %h", $time, name, want, got);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("failure at %0t: %s", $time, what);
    endtask

    function automatic axi_addr_t reg_addr(input reg_sel_t sel);
        return {sel, 2'b00};
    endfunction

    // all tasks start and end 1 unit after a rising edge
    task automatic axi_write(input reg_sel_t sel, input axi_data_t data, input axi_strb_t lanes);
        int n;
        awaddr  = reg_addr(sel);
        wdata   = data;
        wstrb   = lanes;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        while (!awready && n < 50)
        begin
            @(posedge axi_clk);
            #1;
            n++;
        end
        if (!awready)
            report_failure("write was never accepted");
        else
            check_value("wready", wready, 1'b1);
        @(posedge axi_clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        n = 0;
        while (!bvalid && n < 50)
        begin
            @(posedge axi_clk);
            #1;
            n++;
        end
        if (!bvalid)
            report_failure("write response never arrived");
        else
            check_value("bresp", bresp, resp_okay);
        @(posedge axi_clk);
        #1;
    endtask

    task automatic axi_read(input reg_sel_t sel, output axi_data_t data);
        int n;
        araddr  = reg_addr(sel);
        arvalid = 1'b1;
        n = 0;
        while (!arready && n < 50)
        begin
            @(posedge axi_clk);
            #1;
            n++;
        end
        if (!arready)
            report_failure("read address was never accepted");
        @(posedge axi_clk);
        #1;
        arvalid = 1'b0;
        n = 0;
        while (!rvalid && n < 50)
        begin
            @(posedge axi_clk);
            #1;
            n++;
        end
        if (!rvalid)
            report_failure("read data never arrived");
        else
            check_value("rresp", rresp, resp_okay);
        data = rdata;
        @(posedge axi_clk);
        #1;
    endtask

    // poll control until the engine drops the start bit
    task automatic wait_transfer();
        axi_data_t ctrl;
        int n;
        n = 0;
        ctrl = '1;
        while (ctrl[ctrl_start] && n < 500)
        begin
            axi_read(reg_control, ctrl);
            n++;
        end
        if (ctrl[ctrl_start])
            report_failure("transfer never finished, start bit stuck");
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        axi_resetn  = 1'b0;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        wvalid      = 1'b0;
        bready      = 1'b1;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b1;
        test_errors = 0;
        repeat (16) @(posedge axi_clk);
        #1;
        axi_resetn = 1'b1;
        @(posedge axi_clk);
        #1;

        // both fifos empty and nothing else set
        axi_read(reg_status, value);
        check_value("status", value, 32'h24);
        axi_read(reg_control, value);
        check_value("control", value, 32'h0);
        end_test("reset values");

        // register starts at zero and only strobed lanes change
        wdata = $random(seed);
        value = wdata;
        strb  = axi_strb_t'($random(seed));
        expected = '0;
        for (int i = 0; i < 4; i++)
        begin
            if (strb[i])
                expected[i*8 +: 8] = value[i*8 +: 8];
        end
        axi_write(reg_address, value, strb);
        axi_read(reg_address, value);
        check_value("address", value, expected);
        end_test("address byte lanes");

        target = target_addr_t'($random(seed));
        axi_write(reg_address, axi_data_t'(target), 4'hf);

        // write transfers of 1 to 4 bytes
        for (int n = 1; n <= 4; n++)
        begin
            base   = model0.byte_log.size();
            starts = model0.start_count;
            stops  = model0.stop_count;
            for (int i = 0; i < n; i++)
            begin
                sent[i] = byte_t'($random(seed));
                axi_write(reg_data, axi_data_t'(sent[i]), 4'h1);
            end
            axi_write(reg_control, 32'h80 | (n << 1), 4'hf);
            wait_transfer();
            check_value("start conditions", model0.start_count - starts, 1);
            check_value("stop conditions", model0.stop_count - stops, 1);
            check_value("bytes on bus", model0.byte_log.size() - base, n + 1);
            if (model0.byte_log.size() - base == n + 1)
            begin
                check_value("address byte", model0.byte_log[base], {target, 1'b0});
                for (int i = 0; i < n; i++)
                    check_value("write byte", model0.byte_log[base+1+i], sent[i]);
            end
            axi_read(reg_status, value);
            check_value("status.tx_empty", value[stat_tx_empty], 1'b1);
        end
        end_test("write transfers");

        // read of three preloaded bytes with the last one nacked
        for (int i = 0; i < 3; i++)
            model0.read_bytes[i] = byte_t'($random(seed));
        base = model0.byte_log.size();
        axi_write(reg_control, 32'h80 | (3 << 1) | 1, 4'hf);
        wait_transfer();
        if (model0.byte_log.size() > base)
            check_value("address byte", model0.byte_log[base], {target, 1'b1});
        else
            report_failure("no address byte seen on a read");
        for (int i = 0; i < 3; i++)
        begin
            axi_read(reg_data, value);
            check_value("read byte", value, axi_data_t'(model0.read_bytes[i]));
        end
        axi_read(reg_status, value);
        check_value("status.rx_empty", value[stat_rx_empty], 1'b1);
        end_test("read transfer");

        // 17 pushes with the engine idle leave the tx fifo full to the end
        for (int i = 0; i < 17; i++)
            axi_write(reg_data, $random(seed), 4'h1);
        axi_read(reg_status, value);
        check_value("status.tx_full", value[stat_tx_full], 1'b1);
        check_value("status.tx_overflow", value[stat_tx_overflow], 1'b1);
        axi_write(reg_status, 32'h1 << stat_tx_overflow, 4'h1);
        axi_read(reg_status, value);
        check_value("status.tx_overflow", value[stat_tx_overflow], 1'b0);
        check_value("status.tx_full", value[stat_tx_full], 1'b1);
        end_test("tx overflow");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- verilog.f
src/axi_regmap_pkg.sv
src/i2c_pkg.sv
src/byte_fifo.sv
src/axi_lite_port.sv
src/i2c_reg_bank.sv
src/i2c_byte_engine.sv
src/i2c_axi_top.sv
bench/i2c_target_model.sv
bench/i2c_axi_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing -Wno-fatal
TOP       := i2c_axi_tb
FILELIST  := verilog.f

.PHONY: all lint clean

all:
	$(VERILATOR) $(FLAGS) --binary --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

lint:
	$(VERILATOR) $(FLAGS) --lint-only --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
